//--- source/exc_pkg.sv
package exc_pkg;

    // ************************************************************
    // Cause.ExcCode values
    // ************************************************************
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12,
        TR   = 5'd13
    } exc_code_t;

    // Redirect FSM toward the fetch unit
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } redir_state_t;

    // ************************************************************
    // CP0 register numbers
    // ************************************************************
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        EBASE    = 5'd15
    } cp0_addr_t;

    localparam logic [31:0] BOOT_BASE   = 32'hbfc0_0200; // Base while Status.BEV is set
    localparam logic [31:0] GEN_OFFSET  = 32'h0000_0180;
    localparam logic [31:0] RESET_EBASE = 32'h8000_0000;

endpackage

//--- source/exc_if.sv
`timescale 1ns/1ns

interface exc_if import exc_pkg::*; ();

    // Taken exception, from the priority logic
    logic        valid;
    exc_code_t   code;
    logic        is_eret;
    logic        branch_delay;
    logic [31:0] epc_value;
    logic [31:0] badvaddr;
    logic        badvaddr_we;
    logic [31:0] target;

    // CP0 state back to the priority logic
    logic        exl;
    logic        bev;
    logic [31:0] ebase;
    logic [31:0] epc_reg;
    logic        int_pending;

    logic        ready; // Redirect FSM idle

    modport prio (output valid, code, is_eret, branch_delay, epc_value, badvaddr,
                  badvaddr_we, target,
                  input  exl, bev, ebase, epc_reg, int_pending, ready);

    modport cp0  (input  valid, ready, code, is_eret, branch_delay, epc_value, badvaddr,
                  badvaddr_we,
                  output exl, bev, ebase, epc_reg, int_pending);

    modport ctrl (input valid, target, output ready);

endinterface

//--- source/exc_priority.sv
`timescale 1ns/1ns

module exc_priority import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        in_delayslot,
    input  logic        data_we,
    input  logic        inst_addr_err,
    input  logic        inst_tlb_miss,
    input  logic        inst_tlb_invalid,
    input  logic        reserved_inst,
    input  logic        overflow,
    input  logic        syscall,
    input  logic        brk,
    input  logic        trap,
    input  logic        data_addr_err,
    input  logic        data_tlb_miss,
    input  logic        data_tlb_invalid,
    input  logic        data_tlb_mod,
    input  logic        eret,
    exc_if.prio         ex
);

    logic [31:0] base;
    logic [31:0] gen_vector;
    logic [31:0] miss_vector;
    logic        take;
    exc_code_t   nxt_code;
    logic        nxt_eret;
    logic [31:0] nxt_badv;
    logic        nxt_badv_we;
    logic [31:0] nxt_target;
    logic        capture;

    assign base        = ex.bev ? BOOT_BASE : ex.ebase;
    assign gen_vector  = base + GEN_OFFSET;
    assign miss_vector = ex.exl ? gen_vector : base; // Refill handler only outside EXL
    assign capture     = ex.ready && !ex.valid;

    // ************************************************************
    // Priority select, highest first
    // ************************************************************
    always_comb begin
        take        = 1'b1;
        nxt_code    = INT;
        nxt_eret    = 1'b0;
        nxt_badv    = pc;
        nxt_badv_we = 1'b0;
        nxt_target  = gen_vector;
        if (ex.int_pending) begin
            nxt_code = INT;
        end else if (inst_addr_err) begin
            nxt_code    = ADEL;
            nxt_badv_we = 1'b1;
        end else if (inst_tlb_miss) begin
            nxt_code    = TLBL;
            nxt_badv_we = 1'b1;
            nxt_target  = miss_vector;
        end else if (inst_tlb_invalid) begin
            nxt_code    = TLBL;
            nxt_badv_we = 1'b1;
        end else if (reserved_inst) begin
            nxt_code = RI;
        end else if (overflow) begin
            nxt_code = OV;
        end else if (syscall) begin
            nxt_code = SYS;
        end else if (brk) begin
            nxt_code = BP;
        end else if (trap) begin
            nxt_code = TR;
        end else if (data_addr_err) begin
            nxt_code    = data_we ? ADES : ADEL;
            nxt_badv    = data_vaddr;
            nxt_badv_we = 1'b1;
        end else if (data_tlb_miss) begin
            nxt_code    = data_we ? TLBS : TLBL;
            nxt_badv    = data_vaddr;
            nxt_badv_we = 1'b1;
            nxt_target  = miss_vector;
        end else if (data_tlb_invalid) begin
            nxt_code    = data_we ? TLBS : TLBL;
            nxt_badv    = data_vaddr;
            nxt_badv_we = 1'b1;
        end else if (data_tlb_mod && data_we) begin
            nxt_code    = MOD;
            nxt_badv    = data_vaddr;
            nxt_badv_we = 1'b1;
        end else if (eret) begin
            nxt_eret   = 1'b1;
            nxt_target = ex.epc_reg;
        end else begin
            take = 1'b0;
        end
    end

    // ************************************************************
    // Decision register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid <= 1'b0;
        end else if (ex.valid && ex.ready) begin
            ex.valid <= 1'b0; // Transferred
        end else if (capture) begin
            ex.valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ex.code         <= nxt_code;
            ex.is_eret      <= nxt_eret;
            ex.branch_delay <= in_delayslot;
            ex.badvaddr     <= nxt_badv;
            ex.badvaddr_we  <= nxt_badv_we;
            ex.target       <= nxt_target;
            // Nested exception keeps the first return address
            if (ex.exl) begin
                ex.epc_value <= ex.epc_reg;
            end else begin
                ex.epc_value <= in_delayslot ? pc - 32'd4 : pc;
            end
        end
    end

    a_no_rise_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(ex.valid) |-> $past(ex.ready));

endmodule

//--- source/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cp0_we,
    input  cp0_addr_t   cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    input  logic [5:0]  hw_int,
    input  logic        timer_int,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    exc_if.cp0          ex
);

    logic        status_bev;
    logic [7:0]  status_im;
    logic        status_exl;
    logic        status_ie;
    logic        cause_bd;
    exc_code_t   cause_code;
    logic [7:0]  cause_ip;
    logic [31:0] epc;
    logic [31:0] badvaddr;
    logic [31:0] ebase;
    logic        transfer;

    assign transfer = ex.valid && ex.ready;

    // Timer shares line 7 with the top hardware line, no software bits
    assign cause_ip = {hw_int[5] | timer_int, hw_int[4:0], 2'b00};

    assign ex.exl         = status_exl;
    assign ex.bev         = status_bev;
    assign ex.ebase       = ebase;
    assign ex.epc_reg     = epc;
    assign ex.int_pending = status_ie && !status_exl && |(status_im & cause_ip);

    // ************************************************************
    // Register updates, exception wins over a software write
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            status_bev <= 1'b1;
            status_im  <= 8'h00;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
            cause_bd   <= 1'b0;
            cause_code <= INT;
            ebase      <= RESET_EBASE;
        end else begin
            if (cp0_we && cp0_addr == STATUS) begin
                status_bev <= cp0_wdata[22];
                status_im  <= cp0_wdata[15:8];
                status_exl <= cp0_wdata[1];
                status_ie  <= cp0_wdata[0];
            end
            if (cp0_we && cp0_addr == EBASE) begin
                ebase <= {cp0_wdata[31:12], 12'h000}; // 4 KB aligned
            end
            if (transfer && ex.is_eret) begin
                status_exl <= 1'b0;
            end else if (transfer) begin
                status_exl <= 1'b1;
                cause_code <= ex.code;
                cause_bd   <= ex.branch_delay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cp0_we && cp0_addr == EPC) begin
            epc <= cp0_wdata;
        end
        if (transfer && !ex.is_eret && !status_exl) begin
            epc <= ex.epc_value;
        end
        if (transfer && !ex.is_eret && ex.badvaddr_we) begin
            badvaddr <= ex.badvaddr;
        end
    end

    always_comb begin
        case (cp0_addr)
            BADVADDR: cp0_rdata = badvaddr;
            COUNT:    cp0_rdata = count;
            COMPARE:  cp0_rdata = compare;
            STATUS:   cp0_rdata = {9'b0, status_bev, 6'b0, status_im, 6'b0, status_exl, status_ie};
            CAUSE:    cp0_rdata = {cause_bd, 15'b0, cause_ip, 1'b0, cause_code, 2'b00};
            EPC:      cp0_rdata = epc;
            EBASE:    cp0_rdata = ebase;
            default:  cp0_rdata = 32'h0000_0000;
        endcase
    end

    a_eret_clears_exl: assert property (@(posedge clk) disable iff (reset)
        transfer && ex.is_eret |=> !status_exl);

endmodule

//--- source/cp0_timer.sv
`timescale 1ns/1ns

module cp0_timer import exc_pkg::*; #(
    parameter int TIMER_DIV = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cp0_we,
    input  cp0_addr_t   cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);

    localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    assign tick = (div_cnt == DIV_W'(TIMER_DIV - 1));

    // ************************************************************
    // Divider, Count and Compare
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            count     <= 32'h0000_0000;
            compare   <= 32'h0000_0000;
            timer_int <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                count <= count + 32'd1;
                if (count + 32'd1 == compare) begin
                    timer_int <= 1'b1; // Sticky until Compare is written
                end
            end
            if (cp0_we && cp0_addr == COUNT) begin
                count   <= cp0_wdata;
                div_cnt <= '0;
            end
            if (cp0_we && cp0_addr == COMPARE) begin
                compare   <= cp0_wdata;
                timer_int <= 1'b0;
            end
        end
    end

endmodule

//--- source/redirect_ctrl.sv
`timescale 1ns/1ns

module redirect_ctrl import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    exc_if.ctrl         ex,
    output logic        redirect_req,
    input  logic        redirect_ack,
    output logic [31:0] redirect_pc,
    output logic        flush
);

    redir_state_t state;

    assign ex.ready     = (state == IDLE);
    assign redirect_req = (state == REQ);
    assign flush        = (state != IDLE); // Held through the whole handshake

    // ************************************************************
    // Four-phase handshake FSM
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (ex.valid) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (redirect_ack) begin
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!redirect_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid && ex.ready) begin
            redirect_pc <= ex.target;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        $fell(redirect_req) |-> $past(redirect_ack));

    a_pc_stable: assert property (@(posedge clk) disable iff (reset)
        redirect_req |=> $stable(redirect_pc));

endmodule

//--- source/exc_top.sv
`timescale 1ns/1ns

module exc_top import exc_pkg::*; #(
    parameter int TIMER_DIV = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        in_delayslot,
    input  logic        data_we,
    input  logic        inst_addr_err,
    input  logic        inst_tlb_miss,
    input  logic        inst_tlb_invalid,
    input  logic        reserved_inst,
    input  logic        overflow,
    input  logic        syscall,
    input  logic        brk,
    input  logic        trap,
    input  logic        data_addr_err,
    input  logic        data_tlb_miss,
    input  logic        data_tlb_invalid,
    input  logic        data_tlb_mod,
    input  logic        eret,
    input  logic [5:0]  hw_int,
    input  logic        cp0_we,
    input  cp0_addr_t   cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    output logic        redirect_req,
    input  logic        redirect_ack,
    output logic [31:0] redirect_pc,
    output logic        flush
);

    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_int;

    exc_if ex_bus ();

    exc_priority prio_i (
        .clk, .reset, .pc, .data_vaddr, .in_delayslot, .data_we,
        .inst_addr_err, .inst_tlb_miss, .inst_tlb_invalid, .reserved_inst,
        .overflow, .syscall, .brk, .trap, .data_addr_err, .data_tlb_miss,
        .data_tlb_invalid, .data_tlb_mod, .eret,
        .ex (ex_bus.prio)
    );

    cp0_regs regs_i (
        .clk, .reset, .cp0_we, .cp0_addr, .cp0_wdata, .cp0_rdata,
        .hw_int, .timer_int, .count, .compare,
        .ex (ex_bus.cp0)
    );

    cp0_timer #(.TIMER_DIV(TIMER_DIV)) timer_i (
        .clk, .reset, .cp0_we, .cp0_addr, .cp0_wdata,
        .count, .compare, .timer_int
    );

    redirect_ctrl ctrl_i (
        .clk, .reset,
        .ex (ex_bus.ctrl),
        .redirect_req, .redirect_ack, .redirect_pc, .flush
    );

endmodule

//--- verification/exc_tb.sv
`timescale 1ns/1ns

module exc_tb import exc_pkg::*; ();

    // Flag bits from inst_addr_err at bit 12 down to eret at bit 0
    localparam logic [12:0] F_ITLBM = 13'h0800;
    localparam logic [12:0] F_RSVD  = 13'h0200;
    localparam logic [12:0] F_OV    = 13'h0100;
    localparam logic [12:0] F_SYS   = 13'h0080;
    localparam logic [12:0] F_BRK   = 13'h0040;
    localparam logic [12:0] F_TRAP  = 13'h0020;
    localparam logic [12:0] F_DADE  = 13'h0010;
    localparam logic [12:0] F_DTLBM = 13'h0008;
    localparam logic [12:0] F_ERET  = 13'h0001;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] data_vaddr;
    logic        in_delayslot;
    logic        data_we;
    logic [12:0] flags;
    logic [5:0]  hw_int;
    logic        cp0_we;
    cp0_addr_t   cp0_addr;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        redirect_req;
    logic        redirect_ack = 1'b0;
    logic [31:0] redirect_pc;
    logic        flush;

    logic [31:0] lfsr = 32'ha952_0642;
    string       test_name = "reset";
    logic        armed = 1'b0;   // A redirect request is expected
    logic [31:0] exp_target = 32'h0;
    logic        chk_en = 1'b0;
    logic [31:0] chk_mask = 32'h0;
    logic [31:0] chk_exp = 32'h0;
    logic [31:0] ack_delay;
    int          ack_wait;

    // Reference model of the CP0 state
    logic        m_bev = 1'b1;
    logic        m_exl = 1'b0;
    logic [31:0] m_ebase = RESET_EBASE;
    logic [31:0] m_epc = 32'h0;

    exc_top #(.TIMER_DIV(2)) dut_i (
        .clk, .reset, .pc, .data_vaddr, .in_delayslot, .data_we,
        .inst_addr_err(flags[12]), .inst_tlb_miss(flags[11]), .inst_tlb_invalid(flags[10]),
        .reserved_inst(flags[9]), .overflow(flags[8]), .syscall(flags[7]), .brk(flags[6]),
        .trap(flags[5]), .data_addr_err(flags[4]), .data_tlb_miss(flags[3]),
        .data_tlb_invalid(flags[2]), .data_tlb_mod(flags[1]), .eret(flags[0]),
        .hw_int, .cp0_we, .cp0_addr, .cp0_wdata, .cp0_rdata,
        .redirect_req, .redirect_ack, .redirect_pc, .flush
    );

    always #4 clk = ~clk;

    // ************************************************************
    // Helpers
    // ************************************************************
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] exc_vector(input logic miss);
        logic [31:0] base;
        base = m_bev ? BOOT_BASE : m_ebase;
        return (miss && !m_exl) ? base : base + GEN_OFFSET;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s expected %h actual %h", name, exp, act);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_req(input int limit);
        int n;
        n = 0;
        while (!redirect_req && n < limit) begin
            next_cycle();
            n++;
        end
        if (!redirect_req) report_failure({"Timed out waiting for a redirect in ", test_name});
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (flush && n < limit) begin
            next_cycle();
            n++;
        end
        if (flush) report_failure({"Timed out waiting for flush to drop in ", test_name});
    endtask

    task automatic write_reg(input cp0_addr_t addr, input logic [31:0] data);
        cp0_we = 1'b1;
        cp0_addr = addr;
        cp0_wdata = data;
        next_cycle();
        cp0_we = 1'b0;
    endtask

    task automatic check_reg(input string name, input cp0_addr_t addr,
                             input logic [31:0] mask, input logic [31:0] value);
        test_name = name;
        cp0_addr = addr;
        chk_mask = mask;
        chk_exp = value;
        chk_en = 1'b1;
        next_cycle();
        chk_en = 1'b0;
    endtask

    // One exception through the handshake; poke raises syscall while flush is high
    task automatic raise(input string name, input logic [12:0] f, input exc_code_t code,
                         input logic [31:0] target, input logic poke);
        test_name = name;
        exp_target = target;
        if (f != F_ERET && !m_exl) m_epc = in_delayslot ? pc - 32'd4 : pc;
        armed = 1'b1;
        flags = f;
        next_cycle();
        flags = 13'h0;
        wait_req(20);
        armed = 1'b0;
        if (poke) begin
            flags = F_SYS;
            next_cycle();
            flags = 13'h0;
        end
        wait_idle(20);
        m_exl = (f != F_ERET);
        if (f != F_ERET) check_reg(name, CAUSE, 32'h0000_007c, {25'b0, code, 2'b00});
    endtask

    // Fetch side answers after 0 to 3 cycles
    always begin
        next_cycle();
        if (redirect_req && !redirect_ack) begin
            ack_delay = rand_bits(2);
            repeat (ack_delay) next_cycle();
            redirect_ack = 1'b1;
            ack_wait = 0;
            while (redirect_req && ack_wait < 20) begin
                next_cycle();
                ack_wait++;
            end
            if (redirect_req) report_failure("redirect_req stayed high after redirect_ack");
            redirect_ack = 1'b0;
        end
    end

    // ************************************************************
    // Checking properties
    // ************************************************************
    a_target: assert property (@(posedge clk) disable iff (reset)
        $rose(redirect_req) |-> redirect_pc == exp_target)
        else fail_value({test_name, " vector"}, exp_target, redirect_pc);

    a_readback: assert property (@(posedge clk) disable iff (reset)
        chk_en |-> (cp0_rdata & chk_mask) == chk_exp)
        else fail_value(test_name, chk_exp, cp0_rdata & chk_mask);

    a_one_req: assert property (@(posedge clk) disable iff (reset)
        $rose(redirect_req) |-> $past(armed))
        else report_failure("A redirect request came without an accepted exception");

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        redirect_req && !redirect_ack |=> redirect_req)
        else report_failure("redirect_req dropped before redirect_ack was seen");

    a_req_drop: assert property (@(posedge clk) disable iff (reset)
        redirect_req && redirect_ack |=> !redirect_req)
        else report_failure("redirect_req did not drop on the cycle after redirect_ack");

    a_flush: assert property (@(posedge clk) disable iff (reset)
        redirect_req || redirect_ack |-> flush)
        else report_failure("flush was low during the handshake");

    a_pc_stable: assert property (@(posedge clk) disable iff (reset)
        (redirect_req || redirect_ack) && $past(redirect_req || redirect_ack)
        |-> $stable(redirect_pc))
        else report_failure("redirect_pc changed during the handshake");

    // ************************************************************
    // Stimulus
    // ************************************************************
    initial begin
        reset = 1'b1;
        pc = 32'h0;
        data_vaddr = 32'h0;
        in_delayslot = 1'b0;
        data_we = 1'b0;
        flags = 13'h0;
        hw_int = 6'h0;
        cp0_we = 1'b0;
        cp0_addr = STATUS;
        cp0_wdata = 32'h0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        check_reg("reset status", STATUS, 32'h0040_0002, 32'h0040_0000);

        pc = rand_bits(32) & 32'hffff_fffc;
        data_vaddr = rand_bits(32);
        data_we = 1'b1;
        raise("priority", F_OV | F_SYS | F_TRAP | F_DADE, OV, exc_vector(1'b0), 1'b0);
        check_reg("priority epc", EPC, 32'hffff_ffff, m_epc);
        raise("eret", F_ERET, INT, m_epc, 1'b0);
        check_reg("eret status", STATUS, 32'h0000_0002, 32'h0);

        raise("store", F_DADE | F_DTLBM, ADES, exc_vector(1'b0), 1'b0);
        check_reg("store badvaddr", BADVADDR, 32'hffff_ffff, data_vaddr);
        raise("eret", F_ERET, INT, m_epc, 1'b0);
        data_we = 1'b0;
        data_vaddr = rand_bits(32);
        raise("load miss", F_DTLBM | F_ERET, TLBL, exc_vector(1'b1), 1'b0);
        check_reg("load badvaddr", BADVADDR, 32'hffff_ffff, data_vaddr);
        raise("eret", F_ERET, INT, m_epc, 1'b0);

        // Vectors from EBase once BEV is cleared
        m_ebase = rand_bits(32) & 32'hffff_f000;
        write_reg(EBASE, m_ebase);
        write_reg(STATUS, 32'h0);
        m_bev = 1'b0;
        pc = rand_bits(32) & 32'hffff_fffc;
        in_delayslot = 1'b1;
        raise("slot miss", F_ITLBM, TLBL, exc_vector(1'b1), 1'b0);
        check_reg("slot epc", EPC, 32'hffff_ffff, pc - 32'd4);
        check_reg("slot cause bd", CAUSE, 32'h8000_0000, 32'h8000_0000);
        check_reg("inst badvaddr", BADVADDR, 32'hffff_ffff, pc);
        in_delayslot = 1'b0;
        pc = rand_bits(32) & 32'hffff_fffc;
        raise("nested", F_RSVD | F_BRK, RI, exc_vector(1'b0), 1'b0);
        raise("nested miss", F_ITLBM, TLBL, exc_vector(1'b1), 1'b1);
        check_reg("nested epc", EPC, 32'hffff_ffff, m_epc);
        raise("nested eret", F_ERET, INT, m_epc, 1'b0);
        check_reg("nested status", STATUS, 32'h0000_0002, 32'h0);

        // Timer interrupt on line 7
        write_reg(COUNT, 32'h0);
        write_reg(COMPARE, 32'd20);
        write_reg(STATUS, 32'h0000_8001);
        test_name = "timer";
        exp_target = exc_vector(1'b0);
        armed = 1'b1;
        wait_req(200);
        armed = 1'b0;
        wait_idle(20);
        m_exl = 1'b1;
        check_reg("timer cause", CAUSE, 32'h0000_807c, 32'h0000_8000);
        write_reg(COMPARE, 32'h0);
        check_reg("timer clear", CAUSE, 32'h0000_8000, 32'h0);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
source/exc_pkg.sv
source/exc_if.sv
source/exc_priority.sv
source/cp0_regs.sv
source/cp0_timer.sv
source/redirect_ctrl.sv
source/exc_top.sv
verification/exc_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module exc_tb -f tb.f -o exc_tb_sim > sim.log 2>&1 \
    && ./obj_dir/exc_tb_sim >> sim.log 2>&1 \
    || echo "Build or simulation error: Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0
